// File: include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address and word width
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32

// geometry
`define CACHE_SETS        16
`define CACHE_WAYS        2
`define CACHE_BLOCK_WORDS 4

// address field widths
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_WORD_W  $clog2(`CACHE_BLOCK_WORDS)
`define CACHE_BYTE_W  $clog2(`CACHE_DATA_W / 8)
`define CACHE_TAG_W \
  (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WORD_W - `CACHE_BYTE_W)

// backing memory is addressed in words
`define CACHE_WORD_ADDR_W (`CACHE_ADDR_W - `CACHE_BYTE_W)

`endif

// File: design/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  // byte address as the cache sees it
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]   tag;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_WORD_W-1:0]  word;
    logic [`CACHE_BYTE_W-1:0]  byte_off;
  } cache_addr_t;

  // one way's tag state within a set
  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [`CACHE_TAG_W-1:0] tag;
  } tag_entry_t;

  // controller sequence, one request in flight
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict,
    st_refill,
    st_settle,
    st_respond
  } ctrl_state_e;

endpackage

// File: design/lookup_if.sv
`include "cache_macros.svh"

interface lookup_if;

  // read of one set, tag travels with the read
  logic                      rd_en;
  logic [`CACHE_INDEX_W-1:0] index;
  logic [`CACHE_TAG_W-1:0]   tag;

  // entry write and LRU update
  logic                      wr_en;
  logic                      wr_way;
  cache_pkg::tag_entry_t     wr_entry;
  logic                      touch_en;
  logic                      touch_way;

  // lookup results
  logic                      hit;
  logic                      hit_way;
  logic                      victim_way;
  cache_pkg::tag_entry_t     victim_entry;

  modport ctrl (
    output rd_en, index, tag, wr_en, wr_way, wr_entry, touch_en, touch_way,
    input  hit, hit_way, victim_way, victim_entry
  );

  modport tags (
    input  rd_en, index, tag, wr_en, wr_way, wr_entry, touch_en, touch_way,
    output hit, hit_way, victim_way, victim_entry
  );

endinterface

// File: design/data_if.sv
`include "cache_macros.svh"

interface data_if;

  logic                      en;
  logic                      we;
  logic [`CACHE_INDEX_W-1:0] index;
  logic [`CACHE_WORD_W-1:0]  word;

  // write target and payload
  logic                      way;
  logic [`CACHE_DATA_W-1:0]  wdata;

  // both ways side by side, held until the next read
  logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] way_rdata;

  modport ctrl (
    output en, we, index, word, way, wdata,
    input  way_rdata
  );

  modport data (
    input  en, we, index, word, way, wdata,
    output way_rdata
  );

endinterface

// File: design/tag_array.sv
`include "cache_macros.svh"

module tag_array (
  input logic    clk_i,
  input logic    reset_i,
  lookup_if.tags lk
);

  cache_pkg::tag_entry_t entries [`CACHE_SETS][`CACHE_WAYS];

  // per set, points at the way to replace next
  logic lru [`CACHE_SETS];

  // set cleared in the current reset cycle
  logic [`CACHE_INDEX_W-1:0] clr_idx_q;

  // registered copy of the addressed set
  cache_pkg::tag_entry_t     rd_entry_q [`CACHE_WAYS];
  logic [`CACHE_TAG_W-1:0]   rd_tag_q;
  logic                      rd_lru_q;

  // wraps through every set, so sixteen cycles cover the array from any start
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clr_idx_q <= clr_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        entries[clr_idx_q][w] <= '0;
      end
      lru[clr_idx_q] <= 1'b0;
    end else begin
      if (lk.wr_en) begin
        entries[lk.index][lk.wr_way] <= lk.wr_entry;
      end
      // most recently used way is never the next victim
      if (lk.touch_en) begin
        lru[lk.index] <= ~lk.touch_way;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lk.rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        rd_entry_q[w] <= entries[lk.index][w];
      end
      rd_tag_q <= lk.tag;
      rd_lru_q <= lru[lk.index];
    end
  end

  // tag compare on the registered set
  always_comb begin
    lk.hit     = 1'b0;
    lk.hit_way = 1'b0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (rd_entry_q[w].valid && (rd_entry_q[w].tag == rd_tag_q)) begin
        lk.hit     = 1'b1;
        lk.hit_way = w[0];
      end
    end
  end

  assign lk.victim_way   = rd_lru_q;
  assign lk.victim_entry = rd_entry_q[rd_lru_q];

endmodule

// File: design/data_array.sv
`include "cache_macros.svh"

module data_array (
  input logic  clk_i,
  data_if.data dt
);

  // one word store per way, addressed by set and word offset
  logic [`CACHE_DATA_W-1:0] mem [`CACHE_WAYS][`CACHE_SETS * `CACHE_BLOCK_WORDS];

  logic [`CACHE_INDEX_W+`CACHE_WORD_W-1:0] word_addr;

  assign word_addr = {dt.index, dt.word};

  // write touches the selected way only
  always_ff @(posedge clk_i) begin
    if (dt.en && dt.we) begin
      mem[dt.way][word_addr] <= dt.wdata;
    end
  end

  // read returns both ways, output holds until the next read
  always_ff @(posedge clk_i) begin
    if (dt.en && !dt.we) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        dt.way_rdata[w] <= mem[w][word_addr];
      end
    end
  end

endmodule

// File: design/cache_ctrl.sv
`include "cache_macros.svh"

module cache_ctrl (
  input  logic                         clk_i,
  input  logic                         reset_i,

  // requester side
  input  logic                         req_i,
  input  logic                         we_i,
  input  cache_pkg::cache_addr_t       addr_i,
  input  logic [`CACHE_DATA_W-1:0]     wdata_i,
  output logic                         ack_o,
  output logic [`CACHE_DATA_W-1:0]     rdata_o,

  // backing memory side, one word per handshake
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [`CACHE_WORD_ADDR_W-1:0] mem_addr_o,
  output logic [`CACHE_DATA_W-1:0]     mem_wdata_o,
  input  logic                         mem_ack_i,
  input  logic [`CACHE_DATA_W-1:0]     mem_rdata_i,

  lookup_if.ctrl                       lk,
  data_if.ctrl                         dt
);

  cache_pkg::ctrl_state_e state_q;

  // request held for the whole transaction
  cache_pkg::cache_addr_t   addr_q;
  logic                     we_q;
  logic [`CACHE_DATA_W-1:0] wdata_q;

  // victim chosen on the miss
  logic                     vict_way_q;
  logic [`CACHE_TAG_W-1:0]  vict_tag_q;

  logic [`CACHE_WORD_W-1:0] cnt_q;
  logic                     rd_pend_q;

  logic mem_quiet;
  logic word_done;
  logic last_word;
  logic victim_dirty;
  logic evict_rd;
  logic evict_req;
  logic refill_req;

  // both handshake wires low, a new word may start
  assign mem_quiet    = !mem_req_o && !mem_ack_i;
  assign word_done    = mem_req_o && mem_ack_i;
  assign last_word    = (cnt_q == `CACHE_WORD_W'(`CACHE_BLOCK_WORDS - 1));
  assign victim_dirty = lk.victim_entry.valid && lk.victim_entry.dirty;

  assign evict_rd   = (state_q == cache_pkg::st_evict) && mem_quiet && !rd_pend_q;
  assign evict_req  = (state_q == cache_pkg::st_evict) && rd_pend_q;
  assign refill_req = (state_q == cache_pkg::st_refill) && mem_quiet;

  // victim word stays put, no array read happens while the word is out
  assign mem_wdata_o = dt.way_rdata[vict_way_q];

  always_comb begin
    lk.rd_en     = 1'b0;
    lk.index     = addr_q.index;
    lk.tag       = addr_q.tag;
    lk.wr_en     = 1'b0;
    lk.wr_way    = vict_way_q;
    lk.wr_entry  = '{valid: 1'b1, dirty: 1'b0, tag: addr_q.tag};
    lk.touch_en  = 1'b0;
    lk.touch_way = lk.hit_way;

    dt.en    = 1'b0;
    dt.we    = 1'b0;
    dt.index = addr_q.index;
    dt.word  = addr_q.word;
    dt.way   = vict_way_q;
    dt.wdata = wdata_q;

    case (state_q)
      cache_pkg::st_idle: begin
        // both arrays read at the accepting edge
        lk.rd_en = req_i;
        lk.index = addr_i.index;
        lk.tag   = addr_i.tag;
        dt.en    = req_i;
        dt.index = addr_i.index;
        dt.word  = addr_i.word;
      end
      cache_pkg::st_lookup: begin
        if (lk.hit) begin
          lk.touch_en = 1'b1;
          if (we_q) begin
            dt.en       = 1'b1;
            dt.we       = 1'b1;
            dt.way      = lk.hit_way;
            lk.wr_en    = 1'b1;
            lk.wr_way   = lk.hit_way;
            lk.wr_entry = '{valid: 1'b1, dirty: 1'b1, tag: addr_q.tag};
          end
        end
      end
      cache_pkg::st_evict: begin
        dt.en   = evict_rd;
        dt.word = cnt_q;
      end
      cache_pkg::st_refill: begin
        dt.word  = cnt_q;
        dt.wdata = mem_rdata_i;
        if (word_done) begin
          dt.en = 1'b1;
          dt.we = 1'b1;
          // clean tag goes in with the last word
          lk.wr_en = last_word;
        end
      end
      cache_pkg::st_settle: begin
        lk.rd_en = 1'b1;
        dt.en    = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= cache_pkg::st_idle;
      ack_o     <= 1'b0;
      mem_req_o <= 1'b0;
      rd_pend_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      case (state_q)
        cache_pkg::st_idle: begin
          if (req_i) begin
            state_q <= cache_pkg::st_lookup;
          end
        end
        cache_pkg::st_lookup: begin
          cnt_q <= '0;
          if (lk.hit) begin
            state_q <= cache_pkg::st_respond;
          end else if (victim_dirty) begin
            state_q <= cache_pkg::st_evict;
          end else begin
            state_q <= cache_pkg::st_refill;
          end
        end
        cache_pkg::st_evict: begin
          if (evict_rd) begin
            rd_pend_q <= 1'b1;
          end
          if (evict_req) begin
            rd_pend_q <= 1'b0;
            mem_req_o <= 1'b1;
          end
          if (word_done) begin
            mem_req_o <= 1'b0;
            cnt_q     <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= cache_pkg::st_refill;
            end
          end
        end
        cache_pkg::st_refill: begin
          if (refill_req) begin
            mem_req_o <= 1'b1;
          end
          if (word_done) begin
            mem_req_o <= 1'b0;
            cnt_q     <= cnt_q + 1'b1;
            if (last_word) begin
              state_q <= cache_pkg::st_settle;
            end
          end
        end
        cache_pkg::st_settle: begin
          // reread, the request now completes as a hit
          state_q <= cache_pkg::st_lookup;
        end
        cache_pkg::st_respond: begin
          if (!ack_o) begin
            ack_o <= 1'b1;
          end else if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= cache_pkg::st_idle;
          end
        end
        default: begin
          state_q <= cache_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == cache_pkg::st_idle) && req_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    if (state_q == cache_pkg::st_lookup) begin
      rdata_o    <= dt.way_rdata[lk.hit_way];
      vict_way_q <= lk.victim_way;
      vict_tag_q <= lk.victim_entry.tag;
    end
    if (evict_req) begin
      mem_we_o   <= 1'b1;
      mem_addr_o <= {vict_tag_q, addr_q.index, cnt_q};
    end
    if (refill_req) begin
      mem_we_o   <= 1'b0;
      mem_addr_o <= {addr_q.tag, addr_q.index, cnt_q};
    end
  end

endmodule

// File: design/cache_top.sv
`include "cache_macros.svh"

module cache_top (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // requester port
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [`CACHE_ADDR_W-1:0]      addr_i,
  input  logic [`CACHE_DATA_W-1:0]      wdata_i,
  output logic                          ack_o,
  output logic [`CACHE_DATA_W-1:0]      rdata_o,

  // memory port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [`CACHE_WORD_ADDR_W-1:0] mem_addr_o,
  output logic [`CACHE_DATA_W-1:0]      mem_wdata_o,
  input  logic                          mem_ack_i,
  input  logic [`CACHE_DATA_W-1:0]      mem_rdata_i
);

  lookup_if lk ();
  data_if   dt ();

  tag_array u_tag_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lk      (lk)
  );

  data_array u_data_array (
    .clk_i (clk_i),
    .dt    (dt)
  );

  cache_ctrl u_cache_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .lk          (lk),
    .dt          (dt)
  );

endmodule

// File: bench/backing_mem.sv
`include "cache_macros.svh"

module backing_mem (
  input  logic                          clk_i,
  input  logic                          mem_req_i,
  input  logic                          mem_we_i,
  input  logic [`CACHE_WORD_ADDR_W-1:0] mem_addr_i,
  input  logic [`CACHE_DATA_W-1:0]      mem_wdata_i,
  output logic                          mem_ack_o,
  output logic [`CACHE_DATA_W-1:0]      mem_rdata_o
);

  localparam int DRIVE_DELAY = 5;

  // only written words are stored, the rest follow the fill rule
  logic [`CACHE_DATA_W-1:0] store [int];
  int                       delay_left;
  logic                     busy;

  function automatic logic [`CACHE_DATA_W-1:0] read_word(int waddr);
    if (store.exists(waddr)) begin
      return store[waddr];
    end
    return 32'(waddr) * 32'h9e3779b1;
  endfunction

  initial begin
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    busy        = 1'b0;
    delay_left  = 0;
  end

  // four-phase slave, one word per handshake, 0 to 3 cycles of wait
  always @(posedge clk_i) begin
    #(DRIVE_DELAY);
    if (mem_ack_o) begin
      if (!mem_req_i) begin
        mem_ack_o = 1'b0;
      end
    end else if (mem_req_i) begin
      if (!busy) begin
        busy       = 1'b1;
        delay_left = int'($urandom % 4);
      end
      if (delay_left == 0) begin
        if (mem_we_i) begin
          store[int'(mem_addr_i)] = mem_wdata_i;
        end else begin
          mem_rdata_o = read_word(int'(mem_addr_i));
        end
        mem_ack_o = 1'b1;
        busy      = 1'b0;
      end else begin
        delay_left--;
      end
    end
  end

endmodule

// File: bench/cache_tb.sv
`include "cache_macros.svh"

module cache_tb;

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 200;
  localparam int RANDOM_OPS   = 200;
  localparam int POOL_SIZE    = 48;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          req;
  logic                          we;
  logic [`CACHE_ADDR_W-1:0]      addr;
  logic [`CACHE_DATA_W-1:0]      wdata;
  logic                          ack;
  logic [`CACHE_DATA_W-1:0]      rdata;
  logic                          mem_req;
  logic                          mem_we;
  logic [`CACHE_WORD_ADDR_W-1:0] mem_addr;
  logic [`CACHE_DATA_W-1:0]      mem_wdata;
  logic                          mem_ack;
  logic [`CACHE_DATA_W-1:0]      mem_rdata;

  // reference contents, keyed by word address
  logic [`CACHE_DATA_W-1:0] model [int];
  logic [`CACHE_ADDR_W-1:0] pool [POOL_SIZE];

  int   errors       = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   hs_errors    = 0;
  int   mem_reqs     = 0;
  logic prev_ack     = 1'b0;
  logic prev_req     = 1'b0;
  logic prev_mreq    = 1'b0;
  logic prev_mack    = 1'b0;

  event timeout_ev;

  always #(HALF_PERIOD) clk = ~clk;

  cache_top DUT (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .ack_o       (ack),
    .rdata_o     (rdata),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  backing_mem u_mem (
    .clk_i       (clk),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  function automatic int word_addr(logic [`CACHE_ADDR_W-1:0] a);
    return int'(a[`CACHE_ADDR_W-1:`CACHE_BYTE_W]);
  endfunction

  // untouched words read back as word address times the fill constant
  function automatic logic [`CACHE_DATA_W-1:0] model_read(logic [`CACHE_ADDR_W-1:0] a);
    if (model.exists(word_addr(a))) begin
      return model[word_addr(a)];
    end
    return 32'(word_addr(a)) * 32'h9e3779b1;
  endfunction

  task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic confirm(string name, bit cond, string what);
    assert (cond)
    else begin
      $display("%s: %s", name, what);
      errors++;
    end
  endtask

  task automatic verify_handshake(bit cond, string what);
    assert (cond)
    else begin
      $display("handshake: %s", what);
      hs_errors++;
      errors++;
    end
  endtask

  task automatic end_test(string name, int failures);
    tests_run++;
    if (failures == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, failures);
    end
  endtask

  task automatic finish_run();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    $display("timeout: %s", what);
    errors++;
    -> timeout_ev;
  endtask

  // any wait that runs out ends the run here
  initial begin
    @(timeout_ev);
    finish_run();
  end

  // one full four-phase transaction, entered and left just after a rising edge
  task automatic access(input bit write, input logic [`CACHE_ADDR_W-1:0] a,
                        input logic [`CACHE_DATA_W-1:0] d,
                        output logic [`CACHE_DATA_W-1:0] result, output int cycles);
    int n;
    int hold;
    n    = 0;
    hold = int'($urandom % 3);
    while (ack && n < WAIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      n++;
    end
    if (ack) report_timeout("ack_o stayed high before a new request");
    req    = 1'b1;
    we     = write;
    addr   = a;
    wdata  = d;
    cycles = 0;
    while (!ack && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      cycles++;
    end
    if (!ack) report_timeout("ack_o never rose for a request");
    result = rdata;
    // req_i lingers a little, ack_o has to wait for it
    repeat (hold) begin
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    req    = 1'b0;
    n      = 0;
    while (ack && n < WAIT_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      n++;
    end
    if (ack) report_timeout("ack_o stayed high after req_i fell");
    if (write) begin
      model[word_addr(a)] = d;
    end
  endtask

  // both handshakes, checked mid-cycle where every signal is settled
  always @(negedge clk) begin
    if (!reset) begin
      if (prev_ack && prev_req) verify_handshake(ack, "ack_o fell while req_i was high");
      if (!prev_ack && ack) verify_handshake(prev_req, "ack_o rose without req_i");
      if (prev_mreq && !prev_mack) begin
        verify_handshake(mem_req, "mem_req_o fell before mem_ack_i rose");
      end
      if (mem_req && !prev_mreq) mem_reqs++;
    end
    prev_ack  = ack;
    prev_req  = req;
    prev_mreq = mem_req;
    prev_mack = mem_ack;
  end

  initial begin
    logic [`CACHE_DATA_W-1:0] got;
    logic [`CACHE_DATA_W-1:0] val_a;
    logic [`CACHE_DATA_W-1:0] val_b;
    logic [`CACHE_ADDR_W-1:0] a_addr;
    logic [`CACHE_ADDR_W-1:0] b_addr;
    logic [`CACHE_ADDR_W-1:0] c_addr;
    bit                       wr;
    int                       cycles;
    int                       start;
    int                       reqs_before;
    int                       i;
    int                       idx;

    void'($urandom(32'h283a1ec4));
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;

    start = errors;
    confirm("reset", ack == 1'b0, "ack_o high after reset");
    confirm("reset", mem_req == 1'b0, "mem_req_o high after reset");
    end_test("reset", errors - start);

    start  = errors;
    a_addr = {8'h11, 4'h1, 2'h2, 2'b00};
    access(1'b0, a_addr, '0, got, cycles);
    compare_value("read_miss", model_read(a_addr), got);
    end_test("read_miss", errors - start);

    // the read is a hit, so ack_o follows acceptance by exactly 2 cycles
    start  = errors;
    a_addr = {8'h22, 4'h2, 2'h1, 2'b00};
    val_a  = $urandom;
    access(1'b1, a_addr, val_a, got, cycles);
    reqs_before = mem_reqs;
    access(1'b0, a_addr, '0, got, cycles);
    compare_value("write_read", val_a, got);
    compare_value("write_read latency", 32'd2, 32'(cycles - 1));
    confirm("write_read", mem_reqs == reqs_before, "read hit issued a memory request");
    end_test("write_read", errors - start);

    // A and B fill set 3, reading A leaves B as the LRU victim of C
    start  = errors;
    a_addr = {8'h10, 4'h3, 2'h1, 2'b00};
    b_addr = {8'h20, 4'h3, 2'h1, 2'b00};
    c_addr = {8'h30, 4'h3, 2'h1, 2'b00};
    val_a  = $urandom;
    val_b  = $urandom;
    access(1'b1, a_addr, val_a, got, cycles);
    access(1'b1, b_addr, val_b, got, cycles);
    access(1'b0, a_addr, '0, got, cycles);
    compare_value("lru_writeback read A", val_a, got);
    reqs_before = mem_reqs;
    access(1'b0, c_addr, '0, got, cycles);
    compare_value("lru_writeback read C", model_read(c_addr), got);
    compare_value("lru_writeback requests", 32'd8, 32'(mem_reqs - reqs_before));
    compare_value("lru_writeback memory B", val_b, u_mem.read_word(word_addr(b_addr)));
    reqs_before = mem_reqs;
    access(1'b0, a_addr, '0, got, cycles);
    compare_value("lru_writeback reread A", val_a, got);
    confirm("lru_writeback", mem_reqs == reqs_before, "reread of A missed");
    end_test("lru_writeback", errors - start);

    // 4 tags over 3 sets and 4 words, so lines keep evicting each other
    for (i = 0; i < POOL_SIZE; i++) begin
      pool[i] = {8'h40 + 8'(i / 12), 4'(5 + i % 3), 2'((i / 3) % 4), 2'b00};
    end
    start = errors;
    for (i = 0; i < RANDOM_OPS; i++) begin
      idx = int'($urandom % POOL_SIZE);
      wr  = 1'($urandom % 2);
      if (wr) begin
        access(1'b1, pool[idx], $urandom, got, cycles);
      end else begin
        access(1'b0, pool[idx], '0, got, cycles);
        compare_value("random_mix", model_read(pool[idx]), got);
      end
    end
    end_test("random_mix", errors - start);

    end_test("handshake", hs_errors);
    finish_run();
  end

endmodule

// File: wb_cache.f
+incdir+include
design/cache_pkg.sv
design/lookup_if.sv
design/data_if.sv
design/tag_array.sv
design/data_array.sv
design/cache_ctrl.sv
design/cache_top.sv
bench/backing_mem.sv
bench/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= wb_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
